// ==== rtl/ex_pkg.sv ====
// shared types for the execute stage and its data-memory path
// data, address and byte strobe widths
// ALU operation, load and store code values
// load/store unit state machine encoding

`default_nettype none

package ex_pkg;

	typedef logic [63:0] xlen_t;		// register, data and address value
	typedef logic [7:0]  strb_t;		// one bit per byte lane
	typedef logic [2:0]  alu_op_t;
	typedef logic [2:0]  load_code_t;
	typedef logic [2:0]  store_code_t;

	////////////////////////////////////////////////////////////
	// ALU operations, sub and arithmetic shift picked by flags
	////////////////////////////////////////////////////////////
	localparam alu_op_t OP_ADD  = 3'd0;
	localparam alu_op_t OP_SL   = 3'd1;
	localparam alu_op_t OP_SLT  = 3'd2;
	localparam alu_op_t OP_SLTU = 3'd3;
	localparam alu_op_t OP_XOR  = 3'd4;
	localparam alu_op_t OP_SR   = 3'd5;
	localparam alu_op_t OP_OR   = 3'd6;
	localparam alu_op_t OP_AND  = 3'd7;

	////////////////////////////////////////////////////////////
	// memory access codes
	////////////////////////////////////////////////////////////
	localparam load_code_t LD_NONE = 3'd0;
	localparam load_code_t LD_B    = 3'd1;
	localparam load_code_t LD_H    = 3'd2;
	localparam load_code_t LD_W    = 3'd3;
	localparam load_code_t LD_D    = 3'd4;
	localparam load_code_t LD_BU   = 3'd5;
	localparam load_code_t LD_HU   = 3'd6;
	localparam load_code_t LD_WU   = 3'd7;

	localparam store_code_t ST_NONE = 3'd0;
	localparam store_code_t ST_B    = 3'd1;
	localparam store_code_t ST_H    = 3'd2;
	localparam store_code_t ST_W    = 3'd3;
	localparam store_code_t ST_D    = 3'd4;

	typedef enum logic [1:0] {
		IDLE,		// ready for the next instruction
		BUS,		// wishbone cycle open, waiting for ack
		DONE		// result presented for one cycle
	} lsu_state_t;

endpackage

`default_nettype wire

// ==== rtl/ex_alu.sv ====
// combinational RV64 integer ALU
// add/sub, shifts, signed and unsigned compares, logic ops
// word forms truncate to 32 bits and sign-extend the result

`default_nettype none

module ex_alu
	import ex_pkg::*;
(
	input  wire alu_op_t alu_operation,
	input  wire          alu_add_sub,		// high selects subtract
	input  wire          alu_shift,		// high selects arithmetic right shift
	input  wire          word_intercept,		// high selects the W form
	input  wire xlen_t   alu_op_num1,
	input  wire xlen_t   alu_op_num2,
	output xlen_t        alu_result
);

	logic [5:0]  shamt;
	xlen_t       sum;
	xlen_t       shl;
	xlen_t       srl;
	xlen_t       sra;
	logic [31:0] srlw;
	logic [31:0] sraw;
	logic        lt_signed;
	logic        lt_unsigned;

	function automatic xlen_t sext32(input logic [31:0] v);
		return {{32{v[31]}}, v};
	endfunction

	// words only honour five bits of shift amount
	assign shamt = word_intercept ? {1'b0, alu_op_num2[4:0]} : alu_op_num2[5:0];

	assign sum = alu_add_sub ? alu_op_num1 - alu_op_num2 : alu_op_num1 + alu_op_num2;
	assign shl = alu_op_num1 << shamt;
	assign srl = alu_op_num1 >> shamt;
	assign sra = $signed(alu_op_num1) >>> shamt;

	// word right shifts see only the low half, so the fill comes from bit 31
	assign srlw = alu_op_num1[31:0] >> shamt[4:0];
	assign sraw = $signed(alu_op_num1[31:0]) >>> shamt[4:0];

	assign lt_signed   = $signed(alu_op_num1) < $signed(alu_op_num2);
	assign lt_unsigned = alu_op_num1 < alu_op_num2;

	////////////////////////////////////////////////////////////
	// result select
	////////////////////////////////////////////////////////////
	always_comb begin
		case (alu_operation)
			OP_ADD: begin
				alu_result = word_intercept ? sext32(sum[31:0]) : sum;
			end
			OP_SL: begin
				alu_result = word_intercept ? sext32(shl[31:0]) : shl;
			end
			OP_SLT: begin
				alu_result = {63'd0, lt_signed};
			end
			OP_SLTU: begin
				alu_result = {63'd0, lt_unsigned};
			end
			OP_XOR: begin
				alu_result = alu_op_num1 ^ alu_op_num2;
			end
			OP_SR: begin
				if (alu_shift) begin
					alu_result = word_intercept ? sext32(sraw) : sra;
				end else begin
					alu_result = word_intercept ? sext32(srlw) : srl;
				end
			end
			OP_OR: begin
				alu_result = alu_op_num1 | alu_op_num2;
			end
			OP_AND: begin
				alu_result = alu_op_num1 & alu_op_num2;
			end
			default: begin
				alu_result = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== rtl/ex_mem_req.sv ====
// load/store request builder
// turns the load and store codes into a read or write request
// store data is replicated into its lane, strobe follows the offset

`default_nettype none

module ex_mem_req
	import ex_pkg::*;
(
	input  wire load_code_t  load_code,
	input  wire store_code_t store_code,
	input  wire xlen_t       alu_result,		// effective address
	input  wire xlen_t       data_rs2,
	output logic             mem_rd_en,
	output logic             mem_wr_en,
	output xlen_t            mem_addr,
	output xlen_t            mem_wdata,
	output strb_t            mem_sel
);

	logic [2:0] ofs;

	assign ofs       = alu_result[2:0];
	assign mem_addr  = alu_result;
	assign mem_rd_en = load_code != LD_NONE;

	// every lane carries the value, the strobe picks the one that lands
	always_comb begin
		mem_wr_en = 1'b1;
		case (store_code)
			ST_B: begin
				mem_wdata = {8{data_rs2[7:0]}};
				mem_sel   = strb_t'(8'h01 << ofs);
			end
			ST_H: begin
				mem_wdata = {4{data_rs2[15:0]}};
				mem_sel   = strb_t'(8'h03 << ofs);
			end
			ST_W: begin
				mem_wdata = {2{data_rs2[31:0]}};
				mem_sel   = strb_t'(8'h0f << ofs);
			end
			ST_D: begin
				mem_wdata = data_rs2;
				mem_sel   = 8'hff;
			end
			default: begin
				mem_wr_en = 1'b0;
				mem_wdata = '0;
				mem_sel   = '0;
			end
		endcase
	end

	// the decoder upstream must never flag one instruction as both
	a_rd_wr_excl: assert final (!(mem_rd_en === 1'b1 && mem_wr_en === 1'b1))
		else $error("load and store requested together");

endmodule

`default_nettype wire

// ==== rtl/lsu_wb.sv ====
// issue control and result register for the execute stage
// wishbone classic master for single load/store transfers
// load lane extraction with sign or zero extension

`default_nettype none

module lsu_wb
	import ex_pkg::*;
#(
	parameter  int RAM_WORDS = 256,
	localparam int ADR_W     = $clog2(RAM_WORDS) + 3
) (
	input  wire              clk,
	input  wire              rst_n,
	input  wire              issue_valid,
	output logic             issue_ready,
	input  wire xlen_t       alu_result,
	input  wire load_code_t  load_code,
	input  wire              mem_rd_en,
	input  wire              mem_wr_en,
	input  wire xlen_t       mem_addr,
	input  wire xlen_t       mem_wdata,
	input  wire strb_t       mem_sel,
	output logic             result_valid,
	output xlen_t            result_data,
	output logic             wb_cyc,
	output logic             wb_stb,
	output logic             wb_we,
	output logic [ADR_W-1:0] wb_adr,
	output xlen_t            wb_dat_w,
	output strb_t            wb_sel,
	input  wire xlen_t       wb_dat_r,
	input  wire              wb_ack
);

	lsu_state_t state;
	load_code_t ld_code;		// load code held for the whole bus cycle
	xlen_t      req_addr;
	xlen_t      lane;
	xlen_t      ld_data;
	logic       accept;
	logic       mem_req;

	assign issue_ready = state == IDLE;
	assign accept      = issue_valid && issue_ready;
	assign mem_req     = mem_rd_en || mem_wr_en;

	// addressed byte moved down to bit 0
	assign lane = wb_dat_r >> {req_addr[2:0], 3'b000};

	always_comb begin
		case (ld_code)
			LD_B:    ld_data = {{56{lane[7]}}, lane[7:0]};
			LD_H:    ld_data = {{48{lane[15]}}, lane[15:0]};
			LD_W:    ld_data = {{32{lane[31]}}, lane[31:0]};
			LD_BU:   ld_data = {56'd0, lane[7:0]};
			LD_HU:   ld_data = {48'd0, lane[15:0]};
			LD_WU:   ld_data = {32'd0, lane[31:0]};
			default: ld_data = wb_dat_r;
		endcase
	end

	////////////////////////////////////////////////////////////
	// control state
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state        <= IDLE;
			result_valid <= 1'b0;
			wb_cyc       <= 1'b0;
			wb_stb       <= 1'b0;
		end else begin
			result_valid <= 1'b0;
			case (state)
				IDLE: begin
					if (accept && mem_req) begin
						wb_cyc <= 1'b1;
						wb_stb <= 1'b1;
						state  <= BUS;
					end else if (accept) begin
						result_valid <= 1'b1;		// ALU-only, done next cycle
					end
				end
				BUS: begin
					if (wb_ack) begin
						wb_cyc       <= 1'b0;
						wb_stb       <= 1'b0;
						result_valid <= 1'b1;
						state        <= DONE;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// request and result payload
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (accept && mem_req) begin
			wb_we    <= mem_wr_en;
			wb_adr   <= mem_addr[ADR_W-1:0];
			wb_dat_w <= mem_wdata;
			wb_sel   <= mem_wr_en ? mem_sel : 8'hff;		// reads fetch the whole word
			req_addr <= mem_addr;
			ld_code  <= load_code;
		end else if (accept) begin
			result_data <= alu_result;
		end else if (state == BUS && wb_ack) begin
			result_data <= wb_we ? req_addr : ld_data;		// stores report their address
		end
	end

	a_stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n)
		wb_stb |-> wb_cyc);

	a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
		wb_stb && !wb_ack |=> $stable(wb_adr) && $stable(wb_dat_w) && $stable(wb_sel)
			&& $stable(wb_we));

endmodule

`default_nettype wire

// ==== rtl/data_ram.sv ====
// wishbone classic slave RAM, 64 bits wide
// byte-select writes, whole-word reads
// programmable wait states before a single-cycle ack

`default_nettype none

module data_ram
	import ex_pkg::*;
#(
	parameter  int RAM_WORDS = 256,
	parameter  int RAM_WAIT  = 1,
	localparam int ADR_W     = $clog2(RAM_WORDS) + 3
) (
	input  wire              clk,
	input  wire              rst_n,
	input  wire              wb_cyc,
	input  wire              wb_stb,
	input  wire              wb_we,
	input  wire [ADR_W-1:0]  wb_adr,
	input  wire xlen_t       wb_dat_w,
	input  wire strb_t       wb_sel,
	output xlen_t            wb_dat_r,
	output logic             wb_ack
);

	localparam int IDX_W = $clog2(RAM_WORDS);
	localparam int CNT_W = $clog2(RAM_WAIT + 2);

	xlen_t            mem [RAM_WORDS];
	logic [IDX_W-1:0] idx;
	logic [CNT_W-1:0] wait_cnt;
	logic             ack_now;

	assign idx     = IDX_W'(wb_adr[ADR_W-1:3] % RAM_WORDS);		// byte offset dropped
	assign ack_now = wb_cyc && wb_stb && !wb_ack && wait_cnt == CNT_W'(RAM_WAIT);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_ack   <= 1'b0;
			wait_cnt <= '0;
		end else begin
			wb_ack <= ack_now;
			if (wb_cyc && wb_stb && !wb_ack && !ack_now) begin
				wait_cnt <= wait_cnt + 1'b1;
			end else begin
				wait_cnt <= '0;
			end
		end
	end

	// access happens on the edge that raises ack
	always_ff @(posedge clk) begin
		if (ack_now) begin
			if (wb_we) begin
				for (int b = 0; b < 8; b++) begin
					if (wb_sel[b]) begin
						mem[idx][8*b +: 8] <= wb_dat_w[8*b +: 8];
					end
				end
			end
			wb_dat_r <= mem[idx];
		end
	end

	a_ack_with_stb: assert property (@(posedge clk) disable iff (!rst_n)
		wb_ack |-> wb_cyc && wb_stb);

endmodule

`default_nettype wire

// ==== rtl/ex_top.sv ====
// execute stage top level
// ALU, load/store request builder, wishbone master and data RAM

`default_nettype none

module ex_top
	import ex_pkg::*;
#(
	parameter int RAM_WORDS = 256,
	parameter int RAM_WAIT  = 1
) (
	input  wire              clk,
	input  wire              rst_n,
	input  wire              issue_valid,
	output logic             issue_ready,
	input  wire xlen_t       data_rs2,
	input  wire load_code_t  load_code,
	input  wire store_code_t store_code,
	input  wire              alu_add_sub,
	input  wire              alu_shift,
	input  wire              word_intercept,
	input  wire alu_op_t     alu_operation,
	input  wire xlen_t       alu_op_num1,
	input  wire xlen_t       alu_op_num2,
	output logic             result_valid,
	output xlen_t            result_data
);

	localparam int ADR_W = $clog2(RAM_WORDS) + 3;

	xlen_t            alu_result;
	logic             mem_rd_en;
	logic             mem_wr_en;
	xlen_t            mem_addr;
	xlen_t            mem_wdata;
	strb_t            mem_sel;
	logic             wb_cyc;
	logic             wb_stb;
	logic             wb_we;
	logic [ADR_W-1:0] wb_adr;
	xlen_t            wb_dat_w;
	strb_t            wb_sel;
	xlen_t            wb_dat_r;
	logic             wb_ack;

	ex_alu u_alu (
		.alu_operation(alu_operation), .alu_add_sub(alu_add_sub), .alu_shift(alu_shift),
		.word_intercept(word_intercept), .alu_op_num1(alu_op_num1),
		.alu_op_num2(alu_op_num2), .alu_result(alu_result)
	);

	ex_mem_req u_mem_req (
		.load_code(load_code), .store_code(store_code), .alu_result(alu_result),
		.data_rs2(data_rs2), .mem_rd_en(mem_rd_en), .mem_wr_en(mem_wr_en),
		.mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_sel(mem_sel)
	);

	lsu_wb #(.RAM_WORDS(RAM_WORDS)) u_lsu (
		.clk(clk), .rst_n(rst_n), .issue_valid(issue_valid), .issue_ready(issue_ready),
		.alu_result(alu_result), .load_code(load_code), .mem_rd_en(mem_rd_en),
		.mem_wr_en(mem_wr_en), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.mem_sel(mem_sel), .result_valid(result_valid), .result_data(result_data),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_sel(wb_sel), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
	);

	data_ram #(.RAM_WORDS(RAM_WORDS), .RAM_WAIT(RAM_WAIT)) u_ram (
		.clk(clk), .rst_n(rst_n), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_sel(wb_sel),
		.wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
	);

endmodule

`default_nettype wire

// ==== bench/tb_clock.sv ====
// testbench clock and reset source
// 20 ns clock, rst_n held low for 16 cycles

`default_nettype none

module tb_clock (
	output logic clk,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;		// released away from the active edge
	end

endmodule

`default_nettype wire

// ==== bench/tb_ex_top.sv ====
// testbench for the execute stage with its data-memory path
// reference ALU model, byte shadow memory and result tracker
// concurrent assertions for results, latency and issue blocking

`default_nettype none

module tb_ex_top
	import ex_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int RAM_WORDS = 256;
	localparam int RAM_BYTES = RAM_WORDS * 8;
	localparam int TIMEOUT   = 100;

	logic        clk;
	logic        rst_n;
	logic        issue_valid;
	logic        issue_ready;
	xlen_t       data_rs2;
	load_code_t  load_code;
	store_code_t store_code;
	logic        alu_add_sub;
	logic        alu_shift;
	logic        word_intercept;
	alu_op_t     alu_operation;
	xlen_t       alu_op_num1;
	xlen_t       alu_op_num2;
	logic        result_valid;
	xlen_t       result_data;

	xlen_t       exp_q [$];		// one entry per accepted instruction
	xlen_t       exp_head;
	int          exp_cnt;
	logic        mem_busy;
	logic [7:0]  shadow [RAM_BYTES];
	logic [63:0] rng = 64'd75144;
	int          n_errors = 0;
	int          n_results = 0;

	tb_clock u_clock (.clk(clk), .rst_n(rst_n));

	ex_top #(.RAM_WORDS(RAM_WORDS), .RAM_WAIT(2)) DUT (
		.clk(clk), .rst_n(rst_n), .issue_valid(issue_valid), .issue_ready(issue_ready),
		.data_rs2(data_rs2), .load_code(load_code), .store_code(store_code),
		.alu_add_sub(alu_add_sub), .alu_shift(alu_shift), .word_intercept(word_intercept),
		.alu_operation(alu_operation), .alu_op_num1(alu_op_num1),
		.alu_op_num2(alu_op_num2), .result_valid(result_valid), .result_data(result_data)
	);

	////////////////////////////////////////////////////////////
	// reference models
	////////////////////////////////////////////////////////////
	function automatic xlen_t ref_alu(alu_op_t op, logic sub, logic arith, logic w,
			xlen_t a, xlen_t b);
		xlen_t       r;
		logic [31:0] lo;
		int          sh;
		int          i;
		sh = w ? int'(b[4:0]) : int'(b[5:0]);
		r  = '0;
		case (op)
			OP_ADD:  r = sub ? a - b : a + b;
			OP_SL:   r = a << sh;
			OP_SLT:  r = xlen_t'($signed(a) < $signed(b));
			OP_SLTU: r = xlen_t'(a < b);
			OP_XOR:  r = a ^ b;
			OP_OR:   r = a | b;
			OP_AND:  r = a & b;
			default: begin
				// right shift one bit at a time, fill from the top bit when arithmetic
				lo = a[31:0];
				r  = a;
				for (i = 0; i < sh; i++) begin
					lo = {arith & lo[31], lo[31:1]};
					r  = {arith & r[63], r[63:1]};
				end
				if (w) r = {32'd0, lo};
			end
		endcase
		if (w && (op == OP_ADD || op == OP_SL || op == OP_SR)) r = {{32{r[31]}}, r[31:0]};
		return r;
	endfunction

	function automatic int load_size(load_code_t code);
		case (code)
			LD_B, LD_BU: return 1;
			LD_H, LD_HU: return 2;
			LD_W, LD_WU: return 4;
			default:     return 8;
		endcase
	endfunction

	function automatic int store_size(store_code_t code);
		case (code)
			ST_B:    return 1;
			ST_H:    return 2;
			ST_W:    return 4;
			default: return 8;
		endcase
	endfunction

	function automatic xlen_t shadow_load(load_code_t code, int base);
		xlen_t v;
		int    i;
		v = '0;
		for (i = load_size(code) - 1; i >= 0; i--) v = {v[55:0], shadow[base + i]};
		case (code)
			LD_B:    v = {{56{v[7]}}, v[7:0]};
			LD_H:    v = {{48{v[15]}}, v[15:0]};
			LD_W:    v = {{32{v[31]}}, v[31:0]};
			default: ;
		endcase
		return v;
	endfunction

	function automatic logic [63:0] next_rand();
		rng ^= rng << 13;
		rng ^= rng >> 7;
		rng ^= rng << 17;
		return rng;
	endfunction

	function automatic xlen_t fill_pattern(int w);
		return {32'(w) ^ 32'h5a5a_0000, 32'(w) * 32'h9e37_79b1};
	endfunction

	// follows every accepted instruction and predicts its result in order
	always @(posedge clk) begin : track
		xlen_t ea;
		int    base;
		int    i;
		if (rst_n !== 1'b1) begin
			exp_q.delete();
			mem_busy <= 1'b0;
		end else begin
			if (result_valid && exp_q.size() != 0) begin
				void'(exp_q.pop_front());
				n_results++;
				mem_busy <= 1'b0;
			end
			if (issue_valid && issue_ready) begin
				ea = ref_alu(alu_operation, alu_add_sub, alu_shift, word_intercept,
					alu_op_num1, alu_op_num2);
				base = int'(ea & xlen_t'(RAM_BYTES - 1));
				if (store_code != ST_NONE) begin
					for (i = 0; i < store_size(store_code); i++) shadow[base + i] = data_rs2[8*i +: 8];
					exp_q.push_back(ea);		// stores report their address
					mem_busy <= 1'b1;
				end else if (load_code != LD_NONE) begin
					exp_q.push_back(shadow_load(load_code, base));
					mem_busy <= 1'b1;
				end else begin
					exp_q.push_back(ea);
				end
			end
		end
		exp_cnt  <= exp_q.size();
		exp_head <= (exp_q.size() != 0) ? exp_q[0] : '0;
	end

	////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////
	function void report_mismatch(string what, xlen_t got, xlen_t want);
		n_errors++;
		$display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, want);
	endfunction

	function void report_fault(string what);
		n_errors++;
		$display("error at %0t: %s", $time, what);
	endfunction

	a_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !result_valid && issue_ready)
		else report_fault("result_valid high or issue_ready low right after reset");

	a_result_value: assert property (@(posedge clk) disable iff (!rst_n)
		result_valid && exp_cnt != 0 |-> result_data == exp_head)
		else report_mismatch("result_data", $sampled(result_data), $sampled(exp_head));

	a_no_extra: assert property (@(posedge clk) disable iff (!rst_n)
		result_valid |-> exp_cnt != 0)
		else report_fault("result_valid with no instruction outstanding");

	a_alu_latency: assert property (@(posedge clk) disable iff (!rst_n)
		issue_valid && issue_ready && load_code == LD_NONE && store_code == ST_NONE
			|=> result_valid)
		else report_fault("ALU result did not come one cycle after issue");

	a_busy_blocks: assert property (@(posedge clk) disable iff (!rst_n)
		mem_busy |-> !issue_ready)
		else report_fault("issue_ready high while a memory access was in flight");

	a_ready_idle: assert property (@(posedge clk) disable iff (!rst_n)
		!mem_busy |-> issue_ready)
		else report_fault("issue_ready low with no memory access in flight");

	////////////////////////////////////////////////////////////
	// stimulus, driven on the falling edge
	////////////////////////////////////////////////////////////
	task automatic abort_run(string why);
		$display("run aborted at %0t: %s", $time, why);
		$display("TEST RESULT: FAIL");
		$finish;
	endtask

	// issue_valid stays high until the instruction is taken
	task automatic issue(alu_op_t op, logic sub, logic arith, logic w, xlen_t a, xlen_t b,
			load_code_t ld, store_code_t st, xlen_t rs2);
		int waited;
		alu_operation  = op;
		alu_add_sub    = sub;
		alu_shift      = arith;
		word_intercept = w;
		alu_op_num1    = a;
		alu_op_num2    = b;
		load_code      = ld;
		store_code     = st;
		data_rs2       = rs2;
		issue_valid    = 1'b1;
		waited = 0;
		while (!issue_ready && waited < TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		if (!issue_ready) abort_run("issue_ready stayed low past the timeout");
		else @(negedge clk);
	endtask

	task automatic alu(alu_op_t op, logic sub, logic arith, logic w, xlen_t a, xlen_t b);
		issue(op, sub, arith, w, a, b, LD_NONE, ST_NONE, '0);
	endtask

	task automatic store_to(store_code_t st, int addr, xlen_t data);
		issue(OP_ADD, 1'b0, 1'b0, 1'b0, xlen_t'(addr & ~7), xlen_t'(addr & 7), LD_NONE, st, data);
	endtask

	task automatic load_from(load_code_t ld, int addr);
		issue(OP_ADD, 1'b0, 1'b0, 1'b0, xlen_t'(addr & ~7), xlen_t'(addr & 7), ld, ST_NONE, '0);
	endtask

	task automatic go_idle();
		issue_valid = 1'b0;
		@(negedge clk);
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (exp_cnt != 0 && waited < TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		if (exp_cnt != 0) abort_run("results still outstanding past the timeout");
	endtask

	initial begin : stimulus
		store_code_t st_codes [4];
		load_code_t  ld_codes [7];
		logic [63:0] r;
		int          waited;
		int          word;
		int          off;
		int          sz;
		int          k;
		st_codes = '{ST_B, ST_H, ST_W, ST_D};
		ld_codes = '{LD_B, LD_H, LD_W, LD_BU, LD_HU, LD_WU, LD_D};
		issue_valid    = 1'b0;
		data_rs2       = '0;
		load_code      = LD_NONE;
		store_code     = ST_NONE;
		alu_add_sub    = 1'b0;
		alu_shift      = 1'b0;
		word_intercept = 1'b0;
		alu_operation  = OP_ADD;
		alu_op_num1    = '0;
		alu_op_num2    = '0;
		waited = 0;
		while (rst_n !== 1'b1 && waited < 40) begin
			@(negedge clk);
			waited++;
		end
		if (rst_n !== 1'b1) abort_run("reset was never released");
		repeat (2) @(negedge clk);

		// directed ALU cases, back to back
		alu(OP_ADD, 1'b0, 1'b0, 1'b0, 64'd5, 64'd7);
		alu(OP_ADD, 1'b1, 1'b0, 1'b0, 64'd3, 64'd10);
		alu(OP_ADD, 1'b0, 1'b0, 1'b1, 64'h0000_0000_7fff_ffff, 64'd1);
		alu(OP_ADD, 1'b1, 1'b0, 1'b1, 64'h1234_5678_0000_0000, 64'd1);
		alu(OP_SL, 1'b0, 1'b0, 1'b0, 64'd1, 64'd63);
		alu(OP_SL, 1'b0, 1'b0, 1'b1, 64'd1, 64'd31);
		alu(OP_SL, 1'b0, 1'b0, 1'b1, 64'h0000_0000_0000_0003, 64'h25);
		alu(OP_SR, 1'b0, 1'b0, 1'b0, 64'h8000_0000_0000_0000, 64'd4);
		alu(OP_SR, 1'b0, 1'b1, 1'b0, 64'h8000_0000_0000_0000, 64'd4);
		alu(OP_SR, 1'b0, 1'b1, 1'b1, 64'h0000_0000_8000_0000, 64'd4);
		alu(OP_SR, 1'b0, 1'b0, 1'b1, 64'hffff_ffff_8000_0000, 64'd4);
		alu(OP_SR, 1'b0, 1'b1, 1'b0, 64'hffff_ffff_ffff_fff0, 64'd63);
		alu(OP_SLT, 1'b0, 1'b0, 1'b0, 64'hffff_ffff_ffff_ffff, 64'd1);
		alu(OP_SLTU, 1'b0, 1'b0, 1'b0, 64'hffff_ffff_ffff_ffff, 64'd1);
		alu(OP_SLT, 1'b0, 1'b0, 1'b0, 64'd1, 64'hffff_ffff_ffff_ffff);
		alu(OP_SLTU, 1'b0, 1'b0, 1'b0, 64'd1, 64'hffff_ffff_ffff_ffff);
		alu(OP_XOR, 1'b0, 1'b0, 1'b0, 64'hf0f0_0000_ffff_1234, 64'h0ff0_ffff_0000_4321);
		alu(OP_OR, 1'b0, 1'b0, 1'b0, 64'hf0f0_0000_ffff_1234, 64'h0ff0_ffff_0000_4321);
		alu(OP_AND, 1'b0, 1'b0, 1'b0, 64'hf0f0_0000_ffff_1234, 64'h0ff0_ffff_0000_4321);
		go_idle();

		// random ALU traffic with the odd idle cycle
		for (k = 0; k < 200; k++) begin
			r = next_rand();
			alu(r[2:0], r[4], r[5], r[6], next_rand(), r[3] ? next_rand() : {58'd0, r[13:8]});
			if (r[7] && r[20]) go_idle();
		end

		// every word gets a known value so later loads never see stale contents
		for (word = 0; word < RAM_WORDS; word++) store_to(ST_D, word * 8, fill_pattern(word));

		// each store width at each aligned offset, read back as a doubleword
		for (sz = 0; sz < 4; sz++) begin
			for (off = 0; off < 8; off += (1 << sz)) begin
				store_to(st_codes[sz], (16 + 8 * sz + off) * 8 + off, next_rand());
				load_from(LD_D, (16 + 8 * sz + off) * 8);
			end
		end
		for (k = 0; k < 6; k++) begin
			for (off = 0; off < 8; off += load_size(ld_codes[k])) load_from(ld_codes[k], 40 * 8 + off);
		end

		// random loads and stores, some followed by an ALU instruction held during the access
		for (k = 0; k < 150; k++) begin
			r    = next_rand();
			word = int'(r[7:0]);
			if (r[8]) begin
				sz  = int'(r[10:9]);
				off = int'(r[13:11]) & ~((1 << sz) - 1);
				store_to(st_codes[sz], word * 8 + off, next_rand());
			end else begin
				sz  = int'(r[16:14]) % 7;
				off = int'(r[13:11]) & ~(load_size(ld_codes[sz]) - 1);
				load_from(ld_codes[sz], word * 8 + off);
			end
			if (r[20]) alu(OP_ADD, r[21], 1'b0, r[22], next_rand(), next_rand());
		end

		go_idle();
		wait_drain();
		repeat (3) @(negedge clk);
		$display("results checked: %0d, errors: %0d", n_results, n_errors);
		if (n_errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
rtl/ex_pkg.sv
rtl/ex_alu.sv
rtl/ex_mem_req.sv
rtl/lsu_wb.sv
rtl/data_ram.sv
rtl/ex_top.sv
bench/tb_clock.sv
bench/tb_ex_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the execute stage testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_ex_top -f build.f

sim_out="$(./obj_dir/Vtb_ex_top)"
echo "$sim_out"

if grep -qxF "TEST RESULT: PASS" <<< "$sim_out"; then
	exit 0
else
	exit 1
fi
